// ==== afu_mem.f ====
afu_mem_cfg_pkg.sv
afu_csr_pkg.sv
avalon_mem_if.sv
avalon_mem_reg_stage.sv
mem_bank_tester.sv
mmio_csr.sv
afu_mem_top.sv
tb_avalon_mem_model.sv
tb_afu_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_afu_mem -f afu_mem.f

# The simulator exits non-zero on failure, so keep its output for the search
out=$(./obj_dir/Vtb_afu_mem) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"

// ==== tb_afu_mem.sv ====
// Testbench top: clock, reset, MMIO tasks, pattern reference, memory compare, watchdog, tests
`timescale 1ns/100ps

module tb_afu_mem;
    import afu_mem_cfg_pkg::*;
    import afu_csr_pkg::*;

    localparam int CLK_PERIOD = 8;
    // Lines over all runs, sizes the watchdog
    localparam int TOTAL_LINES = 64 + 200 + 32 + 40 + 40;

    logic                 afu_clk;
    logic                 rst_n;
    t_mmio_addr           mmio_address;
    logic                 mmio_read;
    logic                 mmio_write;
    t_mmio_data           mmio_writedata;
    t_mmio_data           mmio_readdata;
    logic                 mmio_readdatavalid;
    t_line_addr           lm_address [NUM_BANKS];
    logic [NUM_BANKS-1:0] lm_read;
    logic [NUM_BANKS-1:0] lm_write;
    t_line_data           lm_writedata [NUM_BANKS];
    logic [NUM_BANKS-1:0] lm_waitrequest;
    t_line_data           lm_readdata [NUM_BANKS];
    logic [NUM_BANKS-1:0] lm_readdatavalid;
    logic                 wait_en;
    logic                 fault_en;
    t_line_addr           fault_addr [3];

    // Request to the comparing process
    logic       cmp_pending;
    string      cmp_name;
    int         cmp_bank;
    logic       cmp_fill;
    t_line_addr cmp_base;
    int         cmp_lines;
    t_line_data cmp_seed;

    afu_mem_top #(.BASE_REG_STAGES(1)) dut
    (
        .afu_clk,
        .rst_n,
        .mmio_address,
        .mmio_read,
        .mmio_write,
        .mmio_writedata,
        .mmio_readdata,
        .mmio_readdatavalid,
        .lm_address,
        .lm_read,
        .lm_write,
        .lm_writedata,
        .lm_waitrequest,
        .lm_readdata,
        .lm_readdatavalid
    );

    // Bank 0 never faults
    tb_avalon_mem_model #(.BANK_ID(0)) model0
    (
        .afu_clk, .rst_n,
        .address(lm_address[0]), .read(lm_read[0]), .write(lm_write[0]),
        .writedata(lm_writedata[0]), .waitrequest(lm_waitrequest[0]),
        .readdata(lm_readdata[0]), .readdatavalid(lm_readdatavalid[0]),
        .wait_en, .fault_en(1'b0), .fault_addr
    );

    tb_avalon_mem_model #(.BANK_ID(1)) model1
    (
        .afu_clk, .rst_n,
        .address(lm_address[1]), .read(lm_read[1]), .write(lm_write[1]),
        .writedata(lm_writedata[1]), .waitrequest(lm_waitrequest[1]),
        .readdata(lm_readdata[1]), .readdatavalid(lm_readdatavalid[1]),
        .wait_en, .fault_en, .fault_addr
    );

    always #(CLK_PERIOD / 2) afu_clk = ~afu_clk;

    // ========================================
    // Reference values
    // ========================================

    // Seed xor zero-extended address, bank number in the top byte
    function automatic t_line_data expect_line(input int bank, input t_line_data s,
                                               input t_line_addr a);
        t_line_data d;
        d = s ^ {{(DATA_WIDTH - ADDR_WIDTH){1'b0}}, a};
        d[63:56] = 8'(bank);
        return d;
    endfunction

    // Contents of a line no run has written
    function automatic t_line_data fill_line(input int bank, input t_line_addr a);
        return {8'hee, 8'(bank), 36'h0, a};
    endfunction

    function automatic t_line_data peek(input int bank, input t_line_addr a);
        if (bank == 0)
            return model0.mem[a];
        return model1.mem[a];
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    // ========================================
    // MMIO access, driven on the falling edge
    // ========================================

    task automatic mmio_wr(input t_mmio_addr addr, input t_mmio_data data);
        @(negedge afu_clk);
        mmio_address   = addr;
        mmio_writedata = data;
        mmio_write     = 1'b1;
        @(negedge afu_clk);
        mmio_write     = 1'b0;
    endtask

    task automatic mmio_rd(input t_mmio_addr addr, output t_mmio_data data);
        @(negedge afu_clk);
        mmio_address = addr;
        mmio_read    = 1'b1;
        @(negedge afu_clk);
        mmio_read    = 1'b0;
        while (!mmio_readdatavalid)
            @(negedge afu_clk);
        data = mmio_readdata;
    endtask

    task automatic configure(input t_line_addr base, input t_line_addr lines,
                             input t_line_data s);
        mmio_wr(CSR_BASE, {52'h0, base});
        mmio_wr(CSR_LINES, {52'h0, lines});
        mmio_wr(CSR_SEED, s);
    endtask

    task automatic start_banks(input logic [NUM_BANKS-1:0] mask);
        t_mmio_data ctrl;
        ctrl = '0;
        ctrl[0] = 1'b1;
        ctrl[CTRL_MASK_LSB +: NUM_BANKS] = mask;
        mmio_wr(CSR_CTRL, ctrl);
    endtask

    // Polls status until every bank in the mask reports done
    task automatic wait_done(input logic [NUM_BANKS-1:0] mask);
        t_mmio_data status;
        mmio_rd(CSR_STATUS, status);
        while ((status[STATUS_DONE_LSB +: NUM_BANKS] & mask) != mask)
            mmio_rd(CSR_STATUS, status);
    endtask

    task automatic read_check(input string name, input t_mmio_addr addr,
                              input t_mmio_data expected);
        t_mmio_data value;
        mmio_rd(addr, value);
        check(name, expected, value);
    endtask

    task automatic compare_mem(input string name, input int bank, input logic fill,
                               input t_line_addr base, input int lines, input t_line_data s);
        cmp_name    = name;
        cmp_bank    = bank;
        cmp_fill    = fill;
        cmp_base    = base;
        cmp_lines   = lines;
        cmp_seed    = s;
        cmp_pending = 1'b1;
        wait (!cmp_pending);
    endtask

    // Model arrays against the reference, addresses wrap like the bank
    always
    begin
        t_line_addr a;
        wait (cmp_pending);
        a = cmp_base;
        for (int i = 0; i < cmp_lines; i++)
        begin
            if (cmp_fill)
                check(cmp_name, fill_line(cmp_bank, a), peek(cmp_bank, a));
            else
                check(cmp_name, expect_line(cmp_bank, cmp_seed, a), peek(cmp_bank, a));
            a = a + 1'b1;
        end
        cmp_pending = 1'b0;
    end

    // Watchdog, 200 cycles per line of all runs
    initial
    begin
        #(TOTAL_LINES * 200 * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_LINES * 200);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    // ========================================
    // Tests
    // ========================================

    initial
    begin
        afu_clk        = 1'b0;
        rst_n          = 1'b0;
        mmio_address   = '0;
        mmio_read      = 1'b0;
        mmio_write     = 1'b0;
        mmio_writedata = '0;
        wait_en        = 1'b0;
        fault_en       = 1'b0;
        fault_addr     = '{12'h403, 12'h410, 12'h41f};
        cmp_pending    = 1'b0;
        repeat (8) @(posedge afu_clk);
        @(negedge afu_clk);
        rst_n = 1'b1;

        // Idle status, identifier, configuration read-back
        read_check("reset status", CSR_STATUS, 64'h0);
        read_check("reset err0", CSR_ERR0, 64'h0);
        read_check("id", CSR_ID, 64'h4146_554d_454d_0001);
        read_check("ctrl reads zero", CSR_CTRL, 64'h0);
        configure(12'h100, 12'd64, 64'h0123_4567_89ab_cdef);
        read_check("base", CSR_BASE, 64'h100);
        read_check("lines", CSR_LINES, 64'd64);
        read_check("seed", CSR_SEED, 64'h0123_4567_89ab_cdef);

        // Bank 0 alone with the configuration above
        start_banks(2'b01);
        wait_done(2'b01);
        read_check("bank0 status", CSR_STATUS, 64'h0000_0001_0000_0000);
        read_check("bank0 err", CSR_ERR0, 64'h0);
        compare_mem("bank0 run", 0, 1'b0, 12'h100, 64, 64'h0123_4567_89ab_cdef);
        compare_mem("bank1 untouched", 1, 1'b1, 12'h000, 4096, 64'h0);

        // Both banks under random back-pressure
        wait_en = 1'b1;
        configure(12'h200, 12'd200, 64'hfeed_face_0bad_f00d);
        start_banks(2'b11);
        read_check("both busy", CSR_STATUS, 64'h0000_0000_0000_0003);
        wait_done(2'b11);
        read_check("both status", CSR_STATUS, 64'h0000_0003_0000_0000);
        read_check("both err0", CSR_ERR0, 64'h0);
        read_check("both err1", CSR_ERR1, 64'h0);
        compare_mem("both bank0", 0, 1'b0, 12'h200, 200, 64'hfeed_face_0bad_f00d);
        compare_mem("both bank1", 1, 1'b0, 12'h200, 200, 64'hfeed_face_0bad_f00d);

        // Three read faults on bank 1 only
        fault_en = 1'b1;
        configure(12'h400, 12'd32, 64'h5a5a_a5a5_3c3c_c3c3);
        start_banks(2'b11);
        wait_done(2'b11);
        read_check("fault err0", CSR_ERR0, 64'h0);
        read_check("fault err1", CSR_ERR1, 64'd3);
        compare_mem("fault bank1", 1, 1'b0, 12'h400, 32, 64'h5a5a_a5a5_3c3c_c3c3);
        fault_en = 1'b0;

        // Run across the top of the space, then again with a new seed
        configure(12'hff0, 12'd40, 64'h1111_2222_3333_4444);
        start_banks(2'b11);
        wait_done(2'b11);
        compare_mem("wrap bank0", 0, 1'b0, 12'hff0, 40, 64'h1111_2222_3333_4444);
        compare_mem("wrap bank1", 1, 1'b0, 12'hff0, 40, 64'h1111_2222_3333_4444);
        check("wrap line 0", expect_line(0, 64'h1111_2222_3333_4444, 12'h000),
              peek(0, 12'h000));
        mmio_wr(CSR_SEED, 64'h9e37_79b9_7f4a_7c15);
        start_banks(2'b11);
        read_check("restart clears done", CSR_STATUS, 64'h0000_0000_0000_0003);
        wait_done(2'b11);
        read_check("restart status", CSR_STATUS, 64'h0000_0003_0000_0000);
        compare_mem("reseed bank0", 0, 1'b0, 12'hff0, 40, 64'h9e37_79b9_7f4a_7c15);
        compare_mem("reseed bank1", 1, 1'b0, 12'hff0, 40, 64'h9e37_79b9_7f4a_7c15);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== tb_avalon_mem_model.sv ====
// Testbench Avalon memory model: line array, random waitrequest, three-cycle reads, read faults
`timescale 1ns/100ps

module tb_avalon_mem_model
#(
    parameter int BANK_ID = 0
)
(
    input  logic                        afu_clk,
    input  logic                        rst_n,
    input  afu_mem_cfg_pkg::t_line_addr address,
    input  logic                        read,
    input  logic                        write,
    input  afu_mem_cfg_pkg::t_line_data writedata,
    output logic                        waitrequest,
    output afu_mem_cfg_pkg::t_line_data readdata,
    output logic                        readdatavalid,
    input  logic                        wait_en,
    input  logic                        fault_en,
    input  afu_mem_cfg_pkg::t_line_addr fault_addr [3]
);
    import afu_mem_cfg_pkg::*;

    localparam int DEPTH   = 2 ** ADDR_WIDTH;
    localparam int LATENCY = 3;

    t_line_data mem [DEPTH];
    logic       pipe_valid [LATENCY];
    t_line_data pipe_data  [LATENCY];
    logic       roll;
    integer     seed;

    // Stored line, bit 0 flipped on a faulty address
    function automatic t_line_data read_value(input t_line_addr a);
        t_line_data d;
        d = mem[a];
        if (fault_en && (a == fault_addr[0] || a == fault_addr[1] || a == fault_addr[2]))
            d[0] = ~d[0];
        return d;
    endfunction

    // Fill tags every line with its bank and its full address
    initial
    begin
        seed = 32'h89fd48e6;
        for (int i = 0; i < DEPTH; i++)
            mem[i] = {8'hee, 8'(BANK_ID), 36'h0, 12'(i)};
    end

    // New stall decision every falling edge
    always @(negedge afu_clk)
    begin
        integer r;
        r = $random(seed);
        roll <= r[1];
    end

    assign waitrequest = wait_en && roll;

    // ========================================
    // Command accept and read pipeline
    // ========================================

    always @(posedge afu_clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < LATENCY; i++)
                pipe_valid[i] <= 1'b0;
        end
        else
        begin
            if (write && !waitrequest)
                mem[address] <= writedata;
            pipe_valid[0] <= read && !waitrequest;
            pipe_data[0]  <= read_value(address);
            for (int i = 1; i < LATENCY; i++)
            begin
                pipe_valid[i] <= pipe_valid[i-1];
                pipe_data[i]  <= pipe_data[i-1];
            end
        end
    end

    assign readdatavalid = pipe_valid[LATENCY-1];
    assign readdata      = pipe_data[LATENCY-1];

endmodule

// ==== afu_mem_top.sv ====
// Accelerator top: MMIO register file, per-bank test engines and register-stage pipelines
`timescale 1ns/100ps

module afu_mem_top
#(
    parameter int BASE_REG_STAGES = 1
)
(
    input  logic                                  afu_clk,
    input  logic                                  rst_n,

    // MMIO, always accepted
    input  afu_csr_pkg::t_mmio_addr               mmio_address,
    input  logic                                  mmio_read,
    input  logic                                  mmio_write,
    input  afu_csr_pkg::t_mmio_data               mmio_writedata,
    output afu_csr_pkg::t_mmio_data               mmio_readdata,
    output logic                                  mmio_readdatavalid,

    // Local memory, one Avalon port per bank
    output afu_mem_cfg_pkg::t_line_addr           lm_address [afu_mem_cfg_pkg::NUM_BANKS],
    output logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] lm_read,
    output logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] lm_write,
    output afu_mem_cfg_pkg::t_line_data           lm_writedata [afu_mem_cfg_pkg::NUM_BANKS],
    input  logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] lm_waitrequest,
    input  afu_mem_cfg_pkg::t_line_data           lm_readdata [afu_mem_cfg_pkg::NUM_BANKS],
    input  logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] lm_readdatavalid
);
    import afu_mem_cfg_pkg::*;

    // Register file to engines
    logic [NUM_BANKS-1:0] start;
    t_line_addr           base_addr;
    t_line_addr           num_lines;
    t_line_data           seed;

    // Engines back to the register file
    logic [NUM_BANKS-1:0] busy;
    logic [NUM_BANKS-1:0] done;
    t_err_count           err_count [NUM_BANKS];

    mmio_csr csr
    (
        .afu_clk,
        .rst_n,
        .mmio_address,
        .mmio_read,
        .mmio_write,
        .mmio_writedata,
        .mmio_readdata,
        .mmio_readdatavalid,
        .start,
        .base_addr,
        .num_lines,
        .seed,
        .busy,
        .done,
        .err_count
    );

    // ========================================
    // Per-bank engine and pipeline
    // ========================================

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        avalon_mem_if tester_if();
        avalon_mem_if lm_if();

        mem_bank_tester #(.BANK_ID(b)) tester
        (
            .afu_clk,
            .rst_n,
            .start(start[b]),
            .base_addr,
            .num_lines,
            .seed,
            .busy(busy[b]),
            .done(done[b]),
            .err_count(err_count[b]),
            .mem(tester_if)
        );

        // Stage count differs per bank to cover timing variants
        avalon_mem_reg_stage #(.N_REG_STAGES(BASE_REG_STAGES + b)) pipe
        (
            .afu_clk,
            .rst_n,
            .upstream(tester_if),
            .downstream(lm_if)
        );

        assign lm_address[b]       = lm_if.address;
        assign lm_read[b]          = lm_if.read;
        assign lm_write[b]         = lm_if.write;
        assign lm_writedata[b]     = lm_if.writedata;
        assign lm_if.waitrequest   = lm_waitrequest[b];
        assign lm_if.readdata      = lm_readdata[b];
        assign lm_if.readdatavalid = lm_readdatavalid[b];
    end

endmodule

// ==== mmio_csr.sv ====
// MMIO register file: test configuration, per-bank start pulses and status read-back
`timescale 1ns/100ps

module mmio_csr
(
    input  logic                                  afu_clk,
    input  logic                                  rst_n,
    input  afu_csr_pkg::t_mmio_addr               mmio_address,
    input  logic                                  mmio_read,
    input  logic                                  mmio_write,
    input  afu_csr_pkg::t_mmio_data               mmio_writedata,
    output afu_csr_pkg::t_mmio_data               mmio_readdata,
    output logic                                  mmio_readdatavalid,
    output logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] start,
    output afu_mem_cfg_pkg::t_line_addr           base_addr,
    output afu_mem_cfg_pkg::t_line_addr           num_lines,
    output afu_mem_cfg_pkg::t_line_data           seed,
    input  logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] busy,
    input  logic [afu_mem_cfg_pkg::NUM_BANKS-1:0] done,
    input  afu_mem_cfg_pkg::t_err_count           err_count [afu_mem_cfg_pkg::NUM_BANKS]
);
    import afu_mem_cfg_pkg::*;
    import afu_csr_pkg::*;

    t_mmio_data rd_mux;

    // ========================================
    // Writes
    // ========================================

    always_ff @(posedge afu_clk)
    begin
        if (!rst_n)
        begin
            start     <= '0;
            base_addr <= '0;
            num_lines <= '0;
            seed      <= '0;
        end
        else
        begin
            // Start lasts one cycle
            start <= '0;
            if (mmio_write)
            begin
                case (mmio_address)
                    CSR_CTRL:
                    begin
                        if (mmio_writedata[0])
                            start <= mmio_writedata[CTRL_MASK_LSB +: NUM_BANKS];
                    end
                    CSR_BASE:
                        base_addr <= mmio_writedata[ADDR_WIDTH-1:0];
                    CSR_LINES:
                        num_lines <= mmio_writedata[ADDR_WIDTH-1:0];
                    CSR_SEED:
                        seed <= mmio_writedata;
                    default:
                        ;
                endcase
            end
        end
    end

    // ========================================
    // Reads
    // ========================================

    // Unmapped and write-only words read as zero
    always_comb
    begin
        rd_mux = '0;
        case (mmio_address)
            CSR_BASE:
                rd_mux[ADDR_WIDTH-1:0] = base_addr;
            CSR_LINES:
                rd_mux[ADDR_WIDTH-1:0] = num_lines;
            CSR_SEED:
                rd_mux = seed;
            CSR_STATUS:
            begin
                rd_mux[NUM_BANKS-1:0]                = busy;
                rd_mux[STATUS_DONE_LSB +: NUM_BANKS] = done;
            end
            CSR_ERR0:
                rd_mux[ERR_WIDTH-1:0] = err_count[0];
            CSR_ERR1:
                rd_mux[ERR_WIDTH-1:0] = err_count[1];
            CSR_ID:
                rd_mux = CSR_ID_VALUE;
            default:
                rd_mux = '0;
        endcase
    end

    // Data valid exactly one cycle after the read
    always_ff @(posedge afu_clk)
    begin
        if (!rst_n)
            mmio_readdatavalid <= 1'b0;
        else
            mmio_readdatavalid <= mmio_read;

        if (mmio_read)
            mmio_readdata <= rd_mux;
    end

    // Host never reads and writes in the same cycle
    a_rd_wr_excl: assert property (@(posedge afu_clk) disable iff (!rst_n)
        !(mmio_read && mmio_write));

endmodule

// ==== mem_bank_tester.sv ====
// Per-bank memory test engine: pattern write, read-back and mismatch count
`timescale 1ns/100ps

module mem_bank_tester
#(
    parameter int BANK_ID = 0
)
(
    input  logic                        afu_clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  afu_mem_cfg_pkg::t_line_addr base_addr,
    input  afu_mem_cfg_pkg::t_line_addr num_lines,
    input  afu_mem_cfg_pkg::t_line_data seed,
    output logic                        busy,
    output logic                        done,
    output afu_mem_cfg_pkg::t_err_count err_count,
    avalon_mem_if.source                mem
);
    import afu_mem_cfg_pkg::*;
    import afu_csr_pkg::*;

    t_tester_state state;

    // Run settings, captured at start
    t_line_addr run_base;
    t_line_addr run_lines;
    t_line_data run_seed;

    // Issue side: next address and commands left in this phase
    t_line_addr issue_addr;
    t_line_addr issue_left;
    // Response side: reads in flight, next address to compare
    t_line_addr outstanding;
    t_line_addr cmp_addr;

    logic cmd_accept;
    logic rd_accept;
    logic mismatch;

    // One line of the pattern, rule in afu_csr_pkg
    function automatic t_line_data pattern(input t_line_data s, input t_line_addr a);
        t_line_data d;
        d = s ^ t_line_data'(a);
        d[DATA_WIDTH-1:PATTERN_BANK_LSB] = (DATA_WIDTH-PATTERN_BANK_LSB)'(BANK_ID);
        return d;
    endfunction

    // Commands come straight from state and issue registers
    assign mem.write     = (state == WRITE);
    assign mem.read      = (state == READ);
    assign mem.address   = issue_addr;
    assign mem.writedata = pattern(run_seed, issue_addr);

    assign cmd_accept = (mem.read || mem.write) && !mem.waitrequest;
    assign rd_accept  = mem.read && !mem.waitrequest;
    assign mismatch   = mem.readdatavalid && (mem.readdata != pattern(run_seed, cmp_addr));

    assign busy = (state == WRITE) || (state == READ) || (state == DRAIN);
    assign done = (state == DONE);

    // ========================================
    // Phase FSM and counters
    // ========================================

    always_ff @(posedge afu_clk)
    begin
        if (!rst_n)
        begin
            state       <= IDLE;
            outstanding <= '0;
            err_count   <= '0;
        end
        else
        begin
            case (state)
                IDLE, DONE:
                begin
                    if (start)
                    begin
                        state     <= WRITE;
                        err_count <= '0;
                    end
                end
                WRITE:
                begin
                    if (cmd_accept && issue_left == t_line_addr'(1))
                        state <= READ;
                end
                READ:
                begin
                    if (cmd_accept && issue_left == t_line_addr'(1))
                        state <= DRAIN;
                end
                // Last response compared
                DRAIN:
                begin
                    if (outstanding == '0)
                        state <= DONE;
                end
                default:
                    state <= IDLE;
            endcase

            outstanding <= outstanding + t_line_addr'(rd_accept)
                           - t_line_addr'(mem.readdatavalid);

            // Saturates at all ones
            if (mismatch && err_count != '1)
                err_count <= err_count + 1'b1;
        end
    end

    // Issue and compare addresses
    always_ff @(posedge afu_clk)
    begin
        if (start && !busy)
        begin
            run_base   <= base_addr;
            run_lines  <= num_lines;
            run_seed   <= seed;
            issue_addr <= base_addr;
            issue_left <= num_lines;
            cmp_addr   <= base_addr;
        end
        else if (cmd_accept)
        begin
            // Reads restart from the base after the last write
            if (state == WRITE && issue_left == t_line_addr'(1))
            begin
                issue_addr <= run_base;
                issue_left <= run_lines;
            end
            else
            begin
                issue_addr <= issue_addr + 1'b1;
                issue_left <= issue_left - 1'b1;
            end
        end

        if (mem.readdatavalid)
            cmp_addr <= cmp_addr + 1'b1;
    end

    // Every response answers a read this engine issued
    a_rsp_expected: assert property (@(posedge afu_clk) disable iff (!rst_n)
        mem.readdatavalid |-> outstanding != '0);

    // Host starts a bank only when idle or done
    a_start_idle: assert property (@(posedge afu_clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

// ==== avalon_mem_reg_stage.sv ====
// Chain of skid-buffered Avalon command stages with matching response registers
`timescale 1ns/100ps

module avalon_mem_reg_stage
#(
    parameter int N_REG_STAGES = 1
)
(
    input  logic         afu_clk,
    input  logic         rst_n,
    avalon_mem_if.sink   upstream,
    avalon_mem_if.source downstream
);
    import afu_mem_cfg_pkg::*;

    // Command taps with index 0 upstream and index N_REG_STAGES downstream
    t_line_addr cmd_addr  [N_REG_STAGES+1];
    t_line_data cmd_wdata [N_REG_STAGES+1];
    logic       cmd_rd    [N_REG_STAGES+1];
    logic       cmd_wr    [N_REG_STAGES+1];
    logic       cmd_wait  [N_REG_STAGES+1];

    // Response taps run the other way with index 0 at the downstream side
    t_line_data rsp_data  [N_REG_STAGES+1];
    logic       rsp_valid [N_REG_STAGES+1];

    assign cmd_addr[0]  = upstream.address;
    assign cmd_wdata[0] = upstream.writedata;
    assign cmd_rd[0]    = upstream.read;
    assign cmd_wr[0]    = upstream.write;
    assign upstream.waitrequest = cmd_wait[0];

    assign downstream.address   = cmd_addr[N_REG_STAGES];
    assign downstream.writedata = cmd_wdata[N_REG_STAGES];
    assign downstream.read      = cmd_rd[N_REG_STAGES];
    assign downstream.write     = cmd_wr[N_REG_STAGES];
    assign cmd_wait[N_REG_STAGES] = downstream.waitrequest;

    assign rsp_data[0]  = downstream.readdata;
    assign rsp_valid[0] = downstream.readdatavalid;
    assign upstream.readdata      = rsp_data[N_REG_STAGES];
    assign upstream.readdatavalid = rsp_valid[N_REG_STAGES];

    // ========================================
    // Register stages or a plain pass-through when there are none
    // ========================================

    for (genvar i = 0; i < N_REG_STAGES; i++)
    begin : g_stage
        // Main entry feeds the next stage
        logic       main_rd;
        logic       main_wr;
        t_line_addr main_addr;
        t_line_data main_wdata;
        // Skid entry catches what arrives while main is stalled
        logic       skid_rd;
        logic       skid_wr;
        t_line_addr skid_addr;
        t_line_data skid_wdata;
        logic       skid_full;
        logic       main_free;
        logic       accept;
        logic       rsp_q_valid;
        t_line_data rsp_q_data;

        assign skid_full = skid_rd || skid_wr;
        // Main moves on when empty or taken downstream
        assign main_free = !(main_rd || main_wr) || !cmd_wait[i+1];
        assign accept    = (cmd_rd[i] || cmd_wr[i]) && !skid_full;

        // Space comes from a flop so upstream never sees a late stall
        assign cmd_wait[i]    = skid_full;
        assign cmd_rd[i+1]    = main_rd;
        assign cmd_wr[i+1]    = main_wr;
        assign cmd_addr[i+1]  = main_addr;
        assign cmd_wdata[i+1] = main_wdata;

        always_ff @(posedge afu_clk)
        begin
            if (!rst_n)
            begin
                main_rd <= 1'b0;
                main_wr <= 1'b0;
                skid_rd <= 1'b0;
                skid_wr <= 1'b0;
            end
            else if (main_free)
            begin
                // Skid entry goes first to keep command order
                main_rd <= skid_full ? skid_rd : cmd_rd[i];
                main_wr <= skid_full ? skid_wr : cmd_wr[i];
                skid_rd <= 1'b0;
                skid_wr <= 1'b0;
            end
            else if (accept)
            begin
                skid_rd <= cmd_rd[i];
                skid_wr <= cmd_wr[i];
            end
        end

        // Payload follows the same moves
        always_ff @(posedge afu_clk)
        begin
            if (main_free)
            begin
                main_addr  <= skid_full ? skid_addr : cmd_addr[i];
                main_wdata <= skid_full ? skid_wdata : cmd_wdata[i];
            end
            else if (accept)
            begin
                skid_addr  <= cmd_addr[i];
                skid_wdata <= cmd_wdata[i];
            end
        end

        // Response path with one register per stage
        always_ff @(posedge afu_clk)
        begin
            if (!rst_n)
                rsp_q_valid <= 1'b0;
            else
                rsp_q_valid <= rsp_valid[i];
            rsp_q_data <= rsp_data[i];
        end

        assign rsp_valid[i+1] = rsp_q_valid;
        assign rsp_data[i+1]  = rsp_q_data;

        // Skid entry only ever holds a command behind an occupied main entry
        a_skid_behind_main: assert property (@(posedge afu_clk) disable iff (!rst_n)
            skid_full |-> main_rd || main_wr);
    end

    // Stalled command from the engine holds until the stage takes it
    a_cmd_stable: assert property (@(posedge afu_clk) disable iff (!rst_n)
        (upstream.read || upstream.write) && upstream.waitrequest
        |=> $stable(upstream.read) && $stable(upstream.write)
            && $stable(upstream.address) && $stable(upstream.writedata));

endmodule

// ==== avalon_mem_if.sv ====
// Avalon memory port of one-line commands with source and sink modports
`timescale 1ns/100ps

interface avalon_mem_if;
    import afu_mem_cfg_pkg::*;

    // Command, held stable while waitrequest is high
    t_line_addr address;
    logic       read;
    logic       write;
    t_line_data writedata;
    logic       waitrequest;

    // In-order read response, never back-pressured
    t_line_data readdata;
    logic       readdatavalid;

    // Command issuer
    modport source
    (
        output address,
        output read,
        output write,
        output writedata,
        input  waitrequest,
        input  readdata,
        input  readdatavalid
    );

    // Command receiver
    modport sink
    (
        input  address,
        input  read,
        input  write,
        input  writedata,
        output waitrequest,
        output readdata,
        output readdatavalid
    );

endinterface

// ==== afu_csr_pkg.sv ====
// MMIO register map, identifier value, pattern rule and test-engine state enum
package afu_csr_pkg;

    // 64-bit MMIO word address and data
    localparam int MMIO_ADDR_WIDTH = 4;
    typedef logic [MMIO_ADDR_WIDTH-1:0] t_mmio_addr;
    typedef logic [63:0] t_mmio_data;

    // ========================================
    // Register map
    // ========================================

    // Write only: bit 0 start, bank-enable mask from bit 8
    localparam t_mmio_addr CSR_CTRL   = 4'h0;
    localparam int         CTRL_MASK_LSB = 8;
    // Base line address of a run
    localparam t_mmio_addr CSR_BASE   = 4'h1;
    // Line count, 1 to 4095
    localparam t_mmio_addr CSR_LINES  = 4'h2;
    localparam t_mmio_addr CSR_SEED   = 4'h3;
    // Busy bits from bit 0, done bits from bit 32
    localparam t_mmio_addr CSR_STATUS = 4'h4;
    localparam int         STATUS_DONE_LSB = 32;
    // Per-bank mismatch counts
    localparam t_mmio_addr CSR_ERR0   = 4'h5;
    localparam t_mmio_addr CSR_ERR1   = 4'h6;
    localparam t_mmio_addr CSR_ID     = 4'h7;
    localparam t_mmio_data CSR_ID_VALUE = 64'h4146_554d_454d_0001;

    // ========================================
    // Pattern rule
    // ========================================

    // Line a of bank b holds seed ^ a, a zero-extended to 64 bits,
    // then bits 63:56 replaced by b
    localparam int PATTERN_BANK_LSB = 56;

    // Test engine phases, run in this order
    typedef enum logic [2:0]
    {
        IDLE,
        WRITE,
        READ,
        DRAIN,
        DONE
    } t_tester_state;

endpackage

// ==== afu_mem_cfg_pkg.sv ====
// Local-memory geometry: bank count, bus widths and line typedefs
package afu_mem_cfg_pkg;

    // Banks exported to the accelerator
    localparam int NUM_BANKS = 2;

    // Line address and line data widths of one bank
    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 64;

    // Mismatch counter width
    localparam int ERR_WIDTH = 16;

    // Line address, wraps at the top of the bank
    typedef logic [ADDR_WIDTH-1:0] t_line_addr;

    // One memory line
    typedef logic [DATA_WIDTH-1:0] t_line_data;

    // Saturating mismatch count
    typedef logic [ERR_WIDTH-1:0] t_err_count;

endpackage
